//--- logic/lsdom_pkg.sv
package lsdom_pkg;

    // Bus widths
    localparam int DATA_W    = 32;
    localparam int STRB_W    = DATA_W / 8;
    localparam int ADDR_W    = 16;

    // Local memory geometry
    localparam int MEM_WORDS = 256;
    localparam int MEM_IDX_W = $clog2(MEM_WORDS);

    // Address map, selected by the top address bit
    localparam logic REGION_MEM = 1'b0;
    localparam logic REGION_CFG = 1'b1;

    // Configuration registers
    localparam int                   REG_IDX_W   = 2;
    localparam logic [REG_IDX_W-1:0] REG_CTRL    = 2'd0;
    localparam logic [REG_IDX_W-1:0] REG_STATUS  = 2'd1;
    localparam logic [REG_IDX_W-1:0] REG_SCRATCH = 2'd2;

    localparam int CTRL_RST_BIT      = 0;
    localparam int CTRL_PAUSE_BIT    = 1;
    localparam int STATUS_PAUSED_BIT = 0;

    // Host-side FSM of the fabric
    localparam logic [2:0] FAB_IDLE    = 3'd0;
    localparam logic [2:0] FAB_ISSUE   = 3'd1;
    localparam logic [2:0] FAB_WAIT    = 3'd2;
    localparam logic [2:0] FAB_ACK     = 3'd3;
    localparam logic [2:0] FAB_RELEASE = 3'd4;

    // Memory adapter FSM
    localparam logic [1:0] ADP_IDLE   = 2'd0;
    localparam logic [1:0] ADP_ISSUE  = 2'd1;
    localparam logic [1:0] ADP_RESP   = 2'd2;
    localparam logic [1:0] ADP_REJECT = 2'd3;

    // Same 16-bit byte address, seen by the memory or by the register block
    typedef union packed {
        struct packed {
            logic                        region;
            logic [ADDR_W-MEM_IDX_W-4:0] pad;
            logic [MEM_IDX_W-1:0]        idx;
            logic [1:0]                  off;
        } mem;
        struct packed {
            logic                        region;
            logic [ADDR_W-REG_IDX_W-4:0] pad;
            logic [REG_IDX_W-1:0]        idx;
            logic [1:0]                  off;
        } cfg;
    } lsdom_addr_u;

endpackage

//--- logic/tag_mem.sv
`timescale 1ns/10ps

module tag_mem (
    input  logic                             lsdom_seq,

    input  logic                             ram_req_i,
    input  logic                             ram_we_i,
    input  logic [lsdom_pkg::MEM_IDX_W-1:0]  ram_idx_i,
    input  logic [lsdom_pkg::STRB_W-1:0]     ram_be_i,
    input  logic [lsdom_pkg::DATA_W-1:0]     ram_wdata_i,
    input  logic                             ram_wtag_i,
    output logic [lsdom_pkg::DATA_W-1:0]     ram_rdata_o,
    output logic                             ram_rtag_o
);
    import lsdom_pkg::*;

    // Data words and their taint tags
    logic [DATA_W-1:0] data_q [MEM_WORDS];
    logic              tag_q  [MEM_WORDS];

    always_ff @(posedge lsdom_seq) begin
        if (ram_req_i) begin
            if (ram_we_i) begin
                for (int b = 0; b < STRB_W; b++) begin
                    if (ram_be_i[b]) begin
                        data_q[ram_idx_i][8*b +: 8] <= ram_wdata_i[8*b +: 8];
                    end
                end
                // Tag follows every write, even a partial one
                tag_q[ram_idx_i] <= ram_wtag_i;
            end else begin
                ram_rdata_o <= data_q[ram_idx_i];
                ram_rtag_o  <= tag_q[ram_idx_i];
            end
        end
    end

    idx_known_on_req: assert property (
        @(posedge lsdom_seq) ram_req_i |-> !$isunknown(ram_idx_i)
    ) else $error("memory request with unknown word index");

endmodule

//--- logic/lpmem_adapter.sv
`timescale 1ns/10ps

module lpmem_adapter (
    input  logic                             lsdom_seq,
    input  logic                             arst_n_i,

    input  logic                             mem_sel_i,
    input  lsdom_pkg::lsdom_addr_u           sel_addr_i,
    input  logic                             sel_we_i,
    input  logic [lsdom_pkg::STRB_W-1:0]     sel_be_i,
    input  logic [lsdom_pkg::DATA_W-1:0]     sel_wdata_i,
    input  logic                             sel_wtag_i,
    output logic                             mem_done_o,
    output logic [lsdom_pkg::DATA_W-1:0]     mem_rdata_o,
    output logic                             mem_rtag_o,
    output logic                             mem_err_o,

    input  logic                             unit_rst_i,
    input  logic                             pause_req_i,
    output logic                             pause_ack_o,

    output logic                             ram_req_o,
    output logic                             ram_we_o,
    output logic [lsdom_pkg::MEM_IDX_W-1:0]  ram_idx_o,
    output logic [lsdom_pkg::STRB_W-1:0]     ram_be_o,
    output logic [lsdom_pkg::DATA_W-1:0]     ram_wdata_o,
    output logic                             ram_wtag_o,
    input  logic [lsdom_pkg::DATA_W-1:0]     ram_rdata_i,
    input  logic                             ram_rtag_i
);
    import lsdom_pkg::*;

    logic [1:0] state_q;
    logic [1:0] state_d;
    logic       reject;
    logic       busy_d;

    // Unit reset and pause keep the FSM from ever starting a memory cycle
    assign reject = (sel_addr_i.mem.pad != '0) || unit_rst_i || pause_ack_o;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ADP_IDLE:  if (mem_sel_i) state_d = reject ? ADP_REJECT : ADP_ISSUE;
            ADP_ISSUE: state_d = ADP_RESP;
            default:   state_d = ADP_IDLE;
        endcase
    end

    assign busy_d = (state_d == ADP_ISSUE) || (state_d == ADP_RESP);

    always_ff @(posedge lsdom_seq or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q     <= ADP_IDLE;
            pause_ack_o <= 1'b0;
        end else begin
            state_q     <= state_d;
            // Grant once idle, hold until the request falls
            pause_ack_o <= pause_req_i && (pause_ack_o || !busy_d);
        end
    end

    // Memory cycle fields, driven the cycle after the strobe
    always_ff @(posedge lsdom_seq) begin
        if (mem_sel_i) begin
            ram_we_o    <= sel_we_i;
            ram_idx_o   <= sel_addr_i.mem.idx;
            ram_be_o    <= sel_be_i;
            ram_wdata_o <= sel_wdata_i;
            ram_wtag_o  <= sel_wtag_i;
        end
    end

    assign ram_req_o   = (state_q == ADP_ISSUE);
    assign mem_done_o  = (state_q == ADP_RESP) || (state_q == ADP_REJECT);
    assign mem_err_o   = (state_q == ADP_REJECT);
    assign mem_rdata_o = ram_rdata_i;
    assign mem_rtag_o  = ram_rtag_i;

    pause_excludes_access: assert property (
        @(posedge lsdom_seq) disable iff (!arst_n_i)
        !(pause_ack_o && (state_q == ADP_ISSUE || state_q == ADP_RESP))
    ) else $error("pause granted while a memory cycle is in flight");

endmodule

//--- logic/lsdom_syscfg.sv
`timescale 1ns/10ps

module lsdom_syscfg (
    input  logic                          lsdom_seq,
    input  logic                          arst_n_i,

    input  logic                          cfg_sel_i,
    input  lsdom_pkg::lsdom_addr_u        sel_addr_i,
    input  logic                          sel_we_i,
    input  logic [lsdom_pkg::STRB_W-1:0]  sel_be_i,
    input  logic [lsdom_pkg::DATA_W-1:0]  sel_wdata_i,
    output logic                          cfg_done_o,
    output logic [lsdom_pkg::DATA_W-1:0]  cfg_rdata_o,
    output logic                          cfg_err_o,

    output logic                          unit_rst_o,
    output logic                          pause_req_o,
    input  logic                          pause_ack_i
);
    import lsdom_pkg::*;

    logic [CTRL_PAUSE_BIT:0]  ctrl_q;
    logic [DATA_W-1:0]        scratch_q;
    logic [DATA_W-1:0]        ctrl_word;
    logic [DATA_W-1:0]        status_word;
    logic [REG_IDX_W-1:0]     reg_idx;
    logic                     unmapped;
    logic                     addr_err;

    assign reg_idx  = sel_addr_i.cfg.idx;
    assign unmapped = !(reg_idx inside {REG_CTRL, REG_STATUS, REG_SCRATCH});
    assign addr_err = (sel_addr_i.cfg.pad != '0) || unmapped;

    // Register images as seen on the bus
    always_comb begin
        ctrl_word                       = '0;
        ctrl_word[CTRL_PAUSE_BIT:0]     = ctrl_q;
        status_word                     = '0;
        status_word[STATUS_PAUSED_BIT]  = pause_ack_i;
    end

    always_ff @(posedge lsdom_seq or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ctrl_q    <= '0;
            scratch_q <= '0;
        end else if (cfg_sel_i && sel_we_i && !addr_err) begin
            case (reg_idx)
                REG_CTRL: begin
                    // Both control bits live in byte 0
                    if (sel_be_i[0]) begin
                        ctrl_q <= sel_wdata_i[CTRL_PAUSE_BIT:0];
                    end
                end
                REG_SCRATCH: begin
                    for (int b = 0; b < STRB_W; b++) begin
                        if (sel_be_i[b]) begin
                            scratch_q[8*b +: 8] <= sel_wdata_i[8*b +: 8];
                        end
                    end
                end
                // STATUS is read-only, writes are dropped
                default: ;
            endcase
        end
    end

    always_ff @(posedge lsdom_seq or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cfg_done_o <= 1'b0;
        end else begin
            cfg_done_o <= cfg_sel_i;
        end
    end

    // Read data and error, valid with cfg_done_o
    always_ff @(posedge lsdom_seq) begin
        if (cfg_sel_i) begin
            cfg_err_o <= addr_err;
            case (reg_idx)
                REG_CTRL:    cfg_rdata_o <= ctrl_word;
                REG_STATUS:  cfg_rdata_o <= status_word;
                REG_SCRATCH: cfg_rdata_o <= scratch_q;
                default:     cfg_rdata_o <= '0;
            endcase
        end
    end

    // Memory unit controls
    assign unit_rst_o  = ctrl_q[CTRL_RST_BIT];
    assign pause_req_o = ctrl_q[CTRL_PAUSE_BIT];

endmodule

//--- logic/lsdom_fabric.sv
`timescale 1ns/10ps

module lsdom_fabric (
    input  logic                          lsdom_seq,
    input  logic                          arst_n_i,

    input  logic                          req_i,
    input  lsdom_pkg::lsdom_addr_u        addr_i,
    input  logic                          we_i,
    input  logic [lsdom_pkg::STRB_W-1:0]  be_i,
    input  logic [lsdom_pkg::DATA_W-1:0]  wdata_i,
    input  logic                          wtag_i,
    output logic                          ack_o,
    output logic [lsdom_pkg::DATA_W-1:0]  rdata_o,
    output logic                          rtag_o,
    output logic                          err_o,

    output logic                          cfg_sel_o,
    output logic                          mem_sel_o,
    output logic                          sel_we_o,
    output logic [lsdom_pkg::STRB_W-1:0]  sel_be_o,
    output logic [lsdom_pkg::DATA_W-1:0]  sel_wdata_o,
    output logic                          sel_wtag_o,
    output lsdom_pkg::lsdom_addr_u        sel_addr_o,

    input  logic                          cfg_done_i,
    input  logic [lsdom_pkg::DATA_W-1:0]  cfg_rdata_i,
    input  logic                          cfg_err_i,
    input  logic                          mem_done_i,
    input  logic [lsdom_pkg::DATA_W-1:0]  mem_rdata_i,
    input  logic                          mem_rtag_i,
    input  logic                          mem_err_i
);
    import lsdom_pkg::*;

    logic [2:0] state_q;
    logic [2:0] state_d;
    logic       is_cfg;
    logic       target_done;

    assign is_cfg      = (sel_addr_o.mem.region == REGION_CFG);
    assign target_done = cfg_done_i | mem_done_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            FAB_IDLE:    if (req_i) state_d = FAB_ISSUE;
            FAB_ISSUE:   state_d = FAB_WAIT;
            FAB_WAIT:    if (target_done) state_d = FAB_ACK;
            FAB_ACK:     if (!req_i) state_d = FAB_RELEASE;
            default:     state_d = FAB_IDLE;
        endcase
    end

    always_ff @(posedge lsdom_seq or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= FAB_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Latch the host request when it is taken
    always_ff @(posedge lsdom_seq) begin
        if (state_q == FAB_IDLE && req_i) begin
            sel_addr_o  <= addr_i;
            sel_we_o    <= we_i;
            sel_be_o    <= be_i;
            sel_wdata_o <= wdata_i;
            sel_wtag_o  <= wtag_i;
        end
    end

    // Response held for the whole acknowledge phase
    always_ff @(posedge lsdom_seq) begin
        if (state_q == FAB_WAIT && target_done) begin
            if (cfg_done_i) begin
                err_o   <= cfg_err_i;
                rdata_o <= (sel_we_o || cfg_err_i) ? '0 : cfg_rdata_i;
                rtag_o  <= 1'b0;
            end else begin
                err_o   <= mem_err_i;
                rdata_o <= (sel_we_o || mem_err_i) ? '0 : mem_rdata_i;
                rtag_o  <= !sel_we_o && !mem_err_i && mem_rtag_i;
            end
        end
    end

    // One-cycle target strobe
    assign cfg_sel_o = (state_q == FAB_ISSUE) && is_cfg;
    assign mem_sel_o = (state_q == FAB_ISSUE) && !is_cfg;
    assign ack_o     = (state_q == FAB_ACK);

    ack_needs_req: assert property (
        @(posedge lsdom_seq) disable iff (!arst_n_i) $rose(ack_o) |-> req_i
    ) else $error("ack_o rose without a pending host request");

endmodule

//--- logic/adam_lsdom.sv
`timescale 1ns/10ps

module adam_lsdom (
    input  logic                          lsdom_seq,
    input  logic                          arst_n_i,

    input  logic                          req_i,
    input  lsdom_pkg::lsdom_addr_u        addr_i,
    input  logic                          we_i,
    input  logic [lsdom_pkg::STRB_W-1:0]  be_i,
    input  logic [lsdom_pkg::DATA_W-1:0]  wdata_i,
    input  logic                          wtag_i,
    output logic                          ack_o,
    output logic [lsdom_pkg::DATA_W-1:0]  rdata_o,
    output logic                          rtag_o,
    output logic                          err_o
);
    import lsdom_pkg::*;

    // Routed access
    logic              cfg_sel;
    logic              mem_sel;
    logic              sel_we;
    logic [STRB_W-1:0] sel_be;
    logic [DATA_W-1:0] sel_wdata;
    logic              sel_wtag;
    lsdom_addr_u       sel_addr;

    // Target responses
    logic              cfg_done;
    logic [DATA_W-1:0] cfg_rdata;
    logic              cfg_err;
    logic              mem_done;
    logic [DATA_W-1:0] mem_rdata;
    logic              mem_rtag;
    logic              mem_err;

    // Memory unit control
    logic unit_rst;
    logic pause_req;
    logic pause_ack;

    // Memory port
    logic                 ram_req;
    logic                 ram_we;
    logic [MEM_IDX_W-1:0] ram_idx;
    logic [STRB_W-1:0]    ram_be;
    logic [DATA_W-1:0]    ram_wdata;
    logic                 ram_wtag;
    logic [DATA_W-1:0]    ram_rdata;
    logic                 ram_rtag;

    lsdom_fabric u_fabric (
        .lsdom_seq   (lsdom_seq),
        .arst_n_i    (arst_n_i),
        .req_i       (req_i),
        .addr_i      (addr_i),
        .we_i        (we_i),
        .be_i        (be_i),
        .wdata_i     (wdata_i),
        .wtag_i      (wtag_i),
        .ack_o       (ack_o),
        .rdata_o     (rdata_o),
        .rtag_o      (rtag_o),
        .err_o       (err_o),
        .cfg_sel_o   (cfg_sel),
        .mem_sel_o   (mem_sel),
        .sel_we_o    (sel_we),
        .sel_be_o    (sel_be),
        .sel_wdata_o (sel_wdata),
        .sel_wtag_o  (sel_wtag),
        .sel_addr_o  (sel_addr),
        .cfg_done_i  (cfg_done),
        .cfg_rdata_i (cfg_rdata),
        .cfg_err_i   (cfg_err),
        .mem_done_i  (mem_done),
        .mem_rdata_i (mem_rdata),
        .mem_rtag_i  (mem_rtag),
        .mem_err_i   (mem_err)
    );

    lsdom_syscfg u_syscfg (
        .lsdom_seq   (lsdom_seq),
        .arst_n_i    (arst_n_i),
        .cfg_sel_i   (cfg_sel),
        .sel_addr_i  (sel_addr),
        .sel_we_i    (sel_we),
        .sel_be_i    (sel_be),
        .sel_wdata_i (sel_wdata),
        .cfg_done_o  (cfg_done),
        .cfg_rdata_o (cfg_rdata),
        .cfg_err_o   (cfg_err),
        .unit_rst_o  (unit_rst),
        .pause_req_o (pause_req),
        .pause_ack_i (pause_ack)
    );

    lpmem_adapter u_lpmem_adapter (
        .lsdom_seq   (lsdom_seq),
        .arst_n_i    (arst_n_i),
        .mem_sel_i   (mem_sel),
        .sel_addr_i  (sel_addr),
        .sel_we_i    (sel_we),
        .sel_be_i    (sel_be),
        .sel_wdata_i (sel_wdata),
        .sel_wtag_i  (sel_wtag),
        .mem_done_o  (mem_done),
        .mem_rdata_o (mem_rdata),
        .mem_rtag_o  (mem_rtag),
        .mem_err_o   (mem_err),
        .unit_rst_i  (unit_rst),
        .pause_req_i (pause_req),
        .pause_ack_o (pause_ack),
        .ram_req_o   (ram_req),
        .ram_we_o    (ram_we),
        .ram_idx_o   (ram_idx),
        .ram_be_o    (ram_be),
        .ram_wdata_o (ram_wdata),
        .ram_wtag_o  (ram_wtag),
        .ram_rdata_i (ram_rdata),
        .ram_rtag_i  (ram_rtag)
    );

    tag_mem u_tag_mem (
        .lsdom_seq   (lsdom_seq),
        .ram_req_i   (ram_req),
        .ram_we_i    (ram_we),
        .ram_idx_i   (ram_idx),
        .ram_be_i    (ram_be),
        .ram_wdata_i (ram_wdata),
        .ram_wtag_i  (ram_wtag),
        .ram_rdata_o (ram_rdata),
        .ram_rtag_o  (ram_rtag)
    );

endmodule

//--- tests/lsdom_model.svh
`ifndef LSDOM_MODEL_SVH
`define LSDOM_MODEL_SVH

// Expected state of the memory words, their tags and the registers
logic [DATA_W-1:0]    mdl_data [MEM_WORDS];
logic                 mdl_tag  [MEM_WORDS];
logic [1:0]           mdl_ctrl;
logic [DATA_W-1:0]    mdl_scratch;
logic                 mdl_paused;

function automatic void model_reset();
    mdl_ctrl    = '0;
    mdl_scratch = '0;
    mdl_paused  = 1'b0;
endfunction

function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
                                                  input logic [DATA_W-1:0] new_word,
                                                  input logic [STRB_W-1:0] be);
    logic [DATA_W-1:0] res;
    res = old_word;
    for (int b = 0; b < STRB_W; b++) begin
        if (be[b]) begin
            res[8*b +: 8] = new_word[8*b +: 8];
        end
    end
    return res;
endfunction

// Predicts one host access and updates the model state
function automatic void model_access(input logic [ADDR_W-1:0] addr, input logic we,
                                     input logic [STRB_W-1:0] be,
                                     input logic [DATA_W-1:0] wdata, input logic wtag,
                                     output logic exp_err, output logic [DATA_W-1:0] exp_rdata,
                                     output logic exp_rtag);
    logic [7:0] idx;
    logic [1:0] ridx;
    idx       = addr[9:2];
    ridx      = addr[3:2];
    exp_err   = 1'b0;
    exp_rdata = '0;
    exp_rtag  = 1'b0;
    if (addr[15]) begin
        // Configuration region
        exp_err = (addr[14:4] != '0) || (ridx == 2'd3);
        if (!exp_err && we) begin
            if (ridx == REG_CTRL && be[0]) begin
                mdl_ctrl = wdata[1:0];
            end
            if (ridx == REG_SCRATCH) begin
                mdl_scratch = merge_bytes(mdl_scratch, wdata, be);
            end
        end else if (!exp_err) begin
            case (ridx)
                REG_CTRL:   exp_rdata = {30'b0, mdl_ctrl};
                REG_STATUS: exp_rdata = {31'b0, mdl_paused};
                default:    exp_rdata = mdl_scratch;
            endcase
        end
    end else begin
        // Memory region, refused while in unit reset or paused
        exp_err = (addr[14:10] != '0) || mdl_ctrl[CTRL_RST_BIT] || mdl_paused;
        if (!exp_err && we) begin
            mdl_data[idx] = merge_bytes(mdl_data[idx], wdata, be);
            mdl_tag[idx]  = wtag;
        end else if (!exp_err) begin
            exp_rdata = mdl_data[idx];
            exp_rtag  = mdl_tag[idx];
        end
    end
endfunction

`endif

//--- tests/adam_lsdom_tb.sv
`timescale 1ns/10ps

module adam_lsdom_tb;
    import lsdom_pkg::*;

    `include "lsdom_model.svh"

    localparam int ACCESS_COUNT = 256 + 300 + 200;
    localparam int ACK_LIMIT    = 40;

    logic              lsdom_seq = 1'b0;
    logic              arst_n_i;
    logic              req_i;
    lsdom_addr_u       addr_i;
    logic              we_i;
    logic [STRB_W-1:0] be_i;
    logic [DATA_W-1:0] wdata_i;
    logic              wtag_i;
    logic              ack_o;
    logic [DATA_W-1:0] rdata_o;
    logic              rtag_o;
    logic              err_o;

    int          errors = 0;
    int          checks = 0;
    logic [31:0] lfsr_q = 32'h10c01d49;

    adam_lsdom u_adam_lsdom (
        .lsdom_seq (lsdom_seq),
        .arst_n_i  (arst_n_i),
        .req_i     (req_i),
        .addr_i    (addr_i),
        .we_i      (we_i),
        .be_i      (be_i),
        .wdata_i   (wdata_i),
        .wtag_i    (wtag_i),
        .ack_o     (ack_o),
        .rdata_o   (rdata_o),
        .rtag_o    (rtag_o),
        .err_o     (err_o)
    );

    always #10 lsdom_seq = ~lsdom_seq;

    // Taps 32, 22, 2, 1
    function automatic logic lfsr_step();
        logic fb;
        fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_step()};
        end
        return v;
    endfunction

    function automatic logic [15:0] mem_addr(input logic [7:0] idx, input logic [1:0] off);
        return {1'b0, 5'b0, idx, off};
    endfunction

    function automatic logic [15:0] cfg_addr(input logic [1:0] ridx);
        return {1'b1, 11'b0, ridx, 2'b00};
    endfunction

    // Full four-phase host cycle
    task automatic bus_cycle(input logic [15:0] a, input logic w, input logic [3:0] b,
                             input logic [31:0] d, input logic t, output logic e,
                             output logic [31:0] rd, output logic rt);
        int waits;
        @(posedge lsdom_seq);
        req_i   <= 1'b1;
        addr_i  <= a;
        we_i    <= w;
        be_i    <= b;
        wdata_i <= d;
        wtag_i  <= t;
        waits = 0;
        do begin
            @(negedge lsdom_seq);
            waits++;
        end while (!ack_o && waits < ACK_LIMIT);
        if (!ack_o) begin
            errors++;
            $display("no acknowledge from the DUT for address %h at %0t", a, $time);
        end
        e  = err_o;
        rd = rdata_o;
        rt = rtag_o;
        @(posedge lsdom_seq);
        req_i <= 1'b0;
        waits = 0;
        do begin
            @(negedge lsdom_seq);
            waits++;
        end while (ack_o && waits < ACK_LIMIT);
        if (ack_o) begin
            errors++;
            $display("ack_o stayed high after the request was dropped at %0t", $time);
        end
    endtask

    task automatic access_check(input logic [15:0] a, input logic w, input logic [3:0] b,
                                input logic [31:0] d, input logic t);
        logic        e;
        logic [31:0] rd;
        logic        rt;
        logic        exp_e;
        logic [31:0] exp_rd;
        logic        exp_rt;
        bus_cycle(a, w, b, d, t, e, rd, rt);
        model_access(a, w, b, d, t, exp_e, exp_rd, exp_rt);
        checks++;
        if (e !== exp_e) begin
            errors++;
            $display("mismatch at %0t: err_o got %0b expected %0b (addr %h)", $time, e, exp_e, a);
        end
        if (rd !== exp_rd) begin
            errors++;
            $display("mismatch at %0t: rdata_o got %h expected %h (addr %h)",
                     $time, rd, exp_rd, a);
        end
        if (rt !== exp_rt) begin
            errors++;
            $display("mismatch at %0t: rtag_o got %0b expected %0b (addr %h)",
                     $time, rt, exp_rt, a);
        end
    endtask

    // Reads STATUS until the paused bit reaches the wanted value
    task automatic poll_paused(input logic want);
        logic        e;
        logic [31:0] rd;
        logic        rt;
        int          n;
        n = 0;
        do begin
            bus_cycle(cfg_addr(REG_STATUS), 1'b0, 4'h0, 32'h0, 1'b0, e, rd, rt);
            n++;
        end while (rd[STATUS_PAUSED_BIT] !== want && n < 50);
        if (rd[STATUS_PAUSED_BIT] !== want) begin
            errors++;
            $display("STATUS never showed paused=%0b within 50 reads", want);
        end
        mdl_paused = want;
    endtask

    initial begin
        #(ACCESS_COUNT * 200 + 5000);
        $display("Timeout: the test did not reach its end in time");
        $display("Errors found");
        $finish;
    end

    initial begin
        logic [31:0] r;
        logic [31:0] word;
        logic [7:0]  idx;
        logic [3:0]  be;
        logic [1:0]  off;
        logic        we;
        logic        tag;
        arst_n_i = 1'b0;
        req_i    = 1'b0;
        addr_i   = '0;
        we_i     = 1'b0;
        be_i     = '0;
        wdata_i  = '0;
        wtag_i   = 1'b0;
        model_reset();
        repeat (2) @(posedge lsdom_seq);
        arst_n_i <= 1'b1;
        @(negedge lsdom_seq);
        if (ack_o !== 1'b0) begin
            errors++;
            $display("mismatch at %0t: ack_o got %0b expected 0", $time, ack_o);
        end
        access_check(cfg_addr(REG_CTRL), 1'b0, 4'h0, 32'h0, 1'b0);
        access_check(cfg_addr(REG_SCRATCH), 1'b0, 4'h0, 32'h0, 1'b0);
        access_check(cfg_addr(REG_STATUS), 1'b0, 4'h0, 32'h0, 1'b0);

        // Fill every word so later reads see known data
        for (int i = 0; i < MEM_WORDS; i++) begin
            word = rand_bits(32);
            r    = rand_bits(1);
            access_check(mem_addr(i[7:0], 2'b00), 1'b1, 4'hf, word, r[0]);
        end
        for (int i = 0; i < 300; i++) begin
            r    = rand_bits(1);
            we   = r[0];
            r    = rand_bits(8);
            idx  = r[7:0];
            r    = rand_bits(4);
            be   = r[3:0];
            r    = rand_bits(2);
            off  = r[1:0];
            word = rand_bits(32);
            r    = rand_bits(1);
            tag  = r[0];
            access_check(mem_addr(idx, off), we, be, word, tag);
        end

        // Register behavior and address errors
        access_check(cfg_addr(REG_SCRATCH), 1'b1, 4'hf, rand_bits(32), 1'b0);
        access_check(cfg_addr(REG_SCRATCH), 1'b1, 4'b0101, rand_bits(32), 1'b0);
        access_check(cfg_addr(REG_SCRATCH), 1'b0, 4'h0, 32'h0, 1'b0);
        access_check(cfg_addr(REG_STATUS), 1'b1, 4'hf, 32'hffff_ffff, 1'b0);
        access_check(cfg_addr(REG_STATUS), 1'b0, 4'h0, 32'h0, 1'b0);
        access_check(cfg_addr(2'd3), 1'b1, 4'hf, 32'h1234_567b, 1'b0);
        access_check(cfg_addr(2'd3), 1'b0, 4'h0, 32'h0, 1'b0);
        access_check(cfg_addr(REG_CTRL), 1'b0, 4'h0, 32'h0, 1'b0);
        access_check(cfg_addr(REG_SCRATCH) | 16'h0010, 1'b1, 4'hf, 32'hdead_beef, 1'b0);
        access_check(cfg_addr(REG_SCRATCH), 1'b0, 4'h0, 32'h0, 1'b0);
        r   = rand_bits(8);
        idx = r[7:0];
        access_check(mem_addr(idx, 2'b00) | 16'h0400, 1'b1, 4'hf, 32'hcafe_f00d, 1'b1);
        access_check(mem_addr(idx, 2'b00) | 16'h4000, 1'b0, 4'h0, 32'h0, 1'b0);
        access_check(mem_addr(idx, 2'b00), 1'b0, 4'h0, 32'h0, 1'b0);

        // Pause handshake
        access_check(cfg_addr(REG_CTRL), 1'b1, 4'h1, 32'h2, 1'b0);
        poll_paused(1'b1);
        access_check(cfg_addr(REG_CTRL), 1'b0, 4'h0, 32'h0, 1'b0);
        access_check(mem_addr(idx, 2'b00), 1'b1, 4'hf, rand_bits(32), 1'b1);
        access_check(mem_addr(idx, 2'b00), 1'b0, 4'h0, 32'h0, 1'b0);
        access_check(cfg_addr(REG_CTRL), 1'b1, 4'h1, 32'h0, 1'b0);
        poll_paused(1'b0);
        access_check(mem_addr(idx, 2'b00), 1'b0, 4'h0, 32'h0, 1'b0);
        access_check(mem_addr(idx, 2'b00), 1'b1, 4'h3, rand_bits(32), 1'b0);
        access_check(mem_addr(idx, 2'b00), 1'b0, 4'h0, 32'h0, 1'b0);

        // Unit reset keeps memory contents
        access_check(cfg_addr(REG_CTRL), 1'b1, 4'h1, 32'h1, 1'b0);
        access_check(mem_addr(idx, 2'b00), 1'b1, 4'hf, rand_bits(32), 1'b1);
        access_check(mem_addr(idx, 2'b00), 1'b0, 4'h0, 32'h0, 1'b0);
        access_check(cfg_addr(REG_STATUS), 1'b0, 4'h0, 32'h0, 1'b0);
        access_check(cfg_addr(REG_CTRL), 1'b1, 4'h1, 32'h0, 1'b0);
        access_check(mem_addr(idx, 2'b00), 1'b0, 4'h0, 32'h0, 1'b0);
        for (int i = 0; i < 8; i++) begin
            r = rand_bits(8);
            access_check(mem_addr(r[7:0], 2'b00), 1'b0, 4'h0, 32'h0, 1'b0);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- adam_lsdom.f
+incdir+tests
logic/lsdom_pkg.sv
logic/tag_mem.sv
logic/lpmem_adapter.sv
logic/lsdom_syscfg.sv
logic/lsdom_fabric.sv
logic/adam_lsdom.sv
tests/adam_lsdom_tb.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := adam_lsdom_tb
FILELIST := adam_lsdom.f
OBJ_DIR  := obj_dir
PASS_MSG := No errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
